// ==== src/rx_pkg.sv ====
package rx_pkg;

    // ----------------------------------------------------------------------
    // sample path widths
    // ----------------------------------------------------------------------
    localparam int IQ_W    = 12;
    localparam int PHASE_W = 16;
    localparam int LLR_W   = 8;
    localparam int SHIFT_W = 3;

    // integrator and comb stages per CIC channel
    localparam int CIC_ORDER = 3;

    // ----------------------------------------------------------------------
    // Wishbone register map
    // ----------------------------------------------------------------------
    localparam int WB_ADDR_W = 4;
    localparam int WB_DATA_W = 32;

    // word addresses
    localparam logic [WB_ADDR_W-1:0] REG_PHASE_INC = 4'd0;
    localparam logic [WB_ADDR_W-1:0] REG_LLR_SHIFT = 4'd1;

endpackage

// ==== src/rx_regs.sv ====
`timescale 1ns/1ns

module rx_regs (
    input  logic                         clk_i,
    input  logic                         reset_ni,
    input  logic                         wb_cyc_i,
    input  logic                         wb_stb_i,
    input  logic                         wb_we_i,
    input  logic [rx_pkg::WB_ADDR_W-1:0] wb_adr_i,
    input  logic [rx_pkg::WB_DATA_W-1:0] wb_dat_i,
    output logic [rx_pkg::WB_DATA_W-1:0] wb_dat_o,
    output logic                         wb_ack_o,
    output logic [rx_pkg::PHASE_W-1:0]   phase_inc_o,
    output logic [rx_pkg::SHIFT_W-1:0]   llr_shift_o
);
    import rx_pkg::*;

    logic                 req;
    logic                 wr_en;
    logic [WB_DATA_W-1:0] rd_data;

    assign req   = wb_cyc_i && wb_stb_i;
    assign wr_en = req && wb_we_i && wb_ack_o;

    // one ack per access and never two in a row
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= req && !wb_ack_o;
        end
    end

    // registers load at the end of the ack cycle
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            phase_inc_o <= '0;
            llr_shift_o <= '0;
        end else if (wr_en) begin
            case (wb_adr_i)
                REG_PHASE_INC: phase_inc_o <= wb_dat_i[PHASE_W-1:0];
                REG_LLR_SHIFT: llr_shift_o <= wb_dat_i[SHIFT_W-1:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        rd_data = '0;
        case (wb_adr_i)
            REG_PHASE_INC: rd_data[PHASE_W-1:0] = phase_inc_o;
            REG_LLR_SHIFT: rd_data[SHIFT_W-1:0] = llr_shift_o;
            default: ;
        endcase
    end

    // read data is valid together with ack
    always_ff @(posedge clk_i) begin
        if (req && !wb_ack_o) begin
            wb_dat_o <= rd_data;
        end
    end

endmodule

// ==== src/cfo_rotator.sv ====
`timescale 1ns/1ns

module cfo_rotator (
    input  logic                             clk_i,
    input  logic                             reset_ni,
    input  logic                             in_valid_i,
    input  logic signed [rx_pkg::IQ_W-1:0]   in_i_i,
    input  logic signed [rx_pkg::IQ_W-1:0]   in_q_i,
    input  logic        [rx_pkg::PHASE_W-1:0] phase_inc_i,
    output logic                             out_valid_o,
    output logic signed [rx_pkg::IQ_W-1:0]   out_i_o,
    output logic signed [rx_pkg::IQ_W-1:0]   out_q_o
);
    import rx_pkg::*;

    localparam logic signed [IQ_W-1:0] IQ_MIN = {1'b1, {(IQ_W-1){1'b0}}};
    localparam logic signed [IQ_W-1:0] IQ_MAX = {1'b0, {(IQ_W-1){1'b1}}};

    logic        [PHASE_W-1:0] phase_q;
    logic        [1:0]         quadrant;
    logic signed [IQ_W-1:0]    rot_i;
    logic signed [IQ_W-1:0]    rot_q;

    // negation that keeps the most negative value in range
    function automatic logic signed [IQ_W-1:0] neg_sat(input logic signed [IQ_W-1:0] x);
        if (x == IQ_MIN) begin
            return IQ_MAX;
        end
        return -x;
    endfunction

    assign quadrant = phase_q[PHASE_W-1 -: 2];

    // clockwise turn by quadrant quarter turns
    always_comb begin
        case (quadrant)
            2'd0: begin
                rot_i = in_i_i;
                rot_q = in_q_i;
            end
            2'd1: begin
                rot_i = in_q_i;
                rot_q = neg_sat(in_i_i);
            end
            2'd2: begin
                rot_i = neg_sat(in_i_i);
                rot_q = neg_sat(in_q_i);
            end
            default: begin
                rot_i = neg_sat(in_q_i);
                rot_q = in_i_i;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            phase_q     <= '0;
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= in_valid_i;
            if (in_valid_i) begin
                // wraps modulo a full turn
                phase_q <= phase_q + phase_inc_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            out_i_o <= rot_i;
            out_q_o <= rot_q;
        end
    end

endmodule

// ==== src/cic_decimator.sv ====
`timescale 1ns/1ns

module cic_decimator #(
    parameter int CIC_RATE = 4
) (
    input  logic                           clk_i,
    input  logic                           reset_ni,
    input  logic                           in_valid_i,
    input  logic signed [rx_pkg::IQ_W-1:0] in_i,
    output logic                           out_valid_o,
    output logic signed [rx_pkg::IQ_W-1:0] out_o
);
    import rx_pkg::*;

    localparam int GROWTH = CIC_ORDER * $clog2(CIC_RATE);
    localparam int ACC_W  = IQ_W + GROWTH;
    localparam int CNT_W  = $clog2(CIC_RATE);

    logic        [CNT_W-1:0] cnt_q;
    logic                    last_in;
    logic signed [ACC_W-1:0] integ_q  [CIC_ORDER];
    logic signed [ACC_W-1:0] integ_d  [CIC_ORDER];
    logic signed [ACC_W-1:0] comb_dly [CIC_ORDER];
    logic signed [ACC_W-1:0] comb_out [CIC_ORDER];

    assign last_in = in_valid_i && (cnt_q == CNT_W'(CIC_RATE - 1));

    // ----------------------------------------------------------------------
    // integrator chain including the current sample
    // ----------------------------------------------------------------------
    always_comb begin
        integ_d[0] = integ_q[0] + ACC_W'(in_i);
        for (int j = 1; j < CIC_ORDER; j++) begin
            integ_d[j] = integ_q[j] + integ_d[j-1];
        end
        // combs with differential delay one
        comb_out[0] = integ_d[CIC_ORDER-1] - comb_dly[0];
        for (int j = 1; j < CIC_ORDER; j++) begin
            comb_out[j] = comb_out[j-1] - comb_dly[j];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            cnt_q       <= '0;
            out_valid_o <= 1'b0;
            for (int j = 0; j < CIC_ORDER; j++) begin
                integ_q[j]  <= '0;
                comb_dly[j] <= '0;
            end
        end else begin
            out_valid_o <= last_in;
            if (in_valid_i) begin
                cnt_q   <= cnt_q + 1'b1;
                integ_q <= integ_d;
            end
            if (last_in) begin
                comb_dly[0] <= integ_d[CIC_ORDER-1];
                for (int j = 1; j < CIC_ORDER; j++) begin
                    comb_dly[j] <= comb_out[j-1];
                end
            end
        end
    end

    // drop the gain growth
    always_ff @(posedge clk_i) begin
        if (last_in) begin
            out_o <= IQ_W'(comb_out[CIC_ORDER-1] >>> GROWTH);
        end
    end

endmodule

// ==== src/llr_demapper.sv ====
`timescale 1ns/1ns

module llr_demapper (
    input  logic                              clk_i,
    input  logic                              reset_ni,
    input  logic                              in_valid_i,
    input  logic signed [rx_pkg::IQ_W-1:0]    in_i_i,
    input  logic signed [rx_pkg::IQ_W-1:0]    in_q_i,
    input  logic        [rx_pkg::SHIFT_W-1:0] llr_shift_i,
    output logic                              out_valid_o,
    output logic signed [rx_pkg::LLR_W-1:0]   llr_i_o,
    output logic signed [rx_pkg::LLR_W-1:0]   llr_q_o
);
    import rx_pkg::*;

    localparam logic signed [IQ_W-1:0] LLR_MAX = IQ_W'((1 <<< (LLR_W - 1)) - 1);
    localparam logic signed [IQ_W-1:0] LLR_MIN = -LLR_MAX - 1;

    // scale then clip to the llr range
    function automatic logic signed [LLR_W-1:0] to_llr(input logic signed [IQ_W-1:0] x,
                                                       input logic [SHIFT_W-1:0] sh);
        logic signed [IQ_W-1:0] scaled;
        scaled = x >>> sh;
        if (scaled > LLR_MAX) begin
            return LLR_W'(LLR_MAX);
        end
        if (scaled < LLR_MIN) begin
            return LLR_W'(LLR_MIN);
        end
        return LLR_W'(scaled);
    endfunction

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= in_valid_i;
        end
    end

    // positive llr means bit 0
    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            llr_i_o <= to_llr(in_i_i, llr_shift_i);
            llr_q_o <= to_llr(in_q_i, llr_shift_i);
        end
    end

endmodule

// ==== src/rx_frontend.sv ====
`timescale 1ns/1ns

module rx_frontend #(
    parameter int CIC_RATE = 4
) (
    input  logic                             clk_i,
    input  logic                             reset_ni,
    input  logic                             wb_cyc_i,
    input  logic                             wb_stb_i,
    input  logic                             wb_we_i,
    input  logic        [rx_pkg::WB_ADDR_W-1:0] wb_adr_i,
    input  logic        [rx_pkg::WB_DATA_W-1:0] wb_dat_i,
    output logic        [rx_pkg::WB_DATA_W-1:0] wb_dat_o,
    output logic                             wb_ack_o,
    input  logic                             in_valid_i,
    input  logic signed [rx_pkg::IQ_W-1:0]   in_i_i,
    input  logic signed [rx_pkg::IQ_W-1:0]   in_q_i,
    output logic                             llr_valid_o,
    output logic signed [rx_pkg::LLR_W-1:0]  llr_i_o,
    output logic signed [rx_pkg::LLR_W-1:0]  llr_q_o
);
    import rx_pkg::*;

    logic        [PHASE_W-1:0] phase_inc;
    logic        [SHIFT_W-1:0] llr_shift;
    logic                      rot_valid;
    logic signed [IQ_W-1:0]    rot_i;
    logic signed [IQ_W-1:0]    rot_q;
    logic                      dec_valid;
    logic signed [IQ_W-1:0]    dec_i;
    logic signed [IQ_W-1:0]    dec_q;

    rx_regs u_regs (
        .clk_i, .reset_ni,
        .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
        .phase_inc_o(phase_inc),
        .llr_shift_o(llr_shift)
    );

    // ----------------------------------------------------------------------
    // rotator -> decimator -> demapper
    // ----------------------------------------------------------------------
    cfo_rotator u_rotator (
        .clk_i, .reset_ni, .in_valid_i, .in_i_i, .in_q_i,
        .phase_inc_i(phase_inc),
        .out_valid_o(rot_valid),
        .out_i_o(rot_i),
        .out_q_o(rot_q)
    );

    // both channels run in lockstep and I carries the valid
    cic_decimator #(.CIC_RATE(CIC_RATE)) cic_re (
        .clk_i, .reset_ni, .in_valid_i(rot_valid), .in_i(rot_i),
        .out_valid_o(dec_valid), .out_o(dec_i)
    );

    cic_decimator #(.CIC_RATE(CIC_RATE)) cic_im (
        .clk_i, .reset_ni, .in_valid_i(rot_valid), .in_i(rot_q),
        .out_valid_o(), .out_o(dec_q)
    );

    llr_demapper u_demapper (
        .clk_i, .reset_ni,
        .in_valid_i(dec_valid), .in_i_i(dec_i), .in_q_i(dec_q),
        .llr_shift_i(llr_shift),
        .out_valid_o(llr_valid_o), .llr_i_o, .llr_q_o
    );

endmodule

// ==== tests/rx_frontend_asserts.sv ====
`timescale 1ns/1ns

module rx_frontend_asserts #(
    parameter int CIC_RATE = 4
) (
    input logic clk_i,
    input logic reset_ni,
    input logic cyc_i,
    input logic stb_i,
    input logic ack_i,
    input logic llr_valid_i
);

    // ----------------------------------------------------------------------
    // wishbone handshake
    // ----------------------------------------------------------------------
    a_ack_single: assert property (@(posedge clk_i) disable iff (!reset_ni)
        ack_i |=> !ack_i)
        else $error("wishbone ack high on two consecutive cycles");

    a_ack_after_req: assert property (@(posedge clk_i) disable iff (!reset_ni)
        ack_i |-> $past(cyc_i && stb_i))
        else $error("wishbone ack without cyc and stb in the cycle before");

    // decimated output can never come back to back
    a_llr_spacing: assert property (@(posedge clk_i) disable iff (!reset_ni)
        ((CIC_RATE >= 2) && llr_valid_i) |=> !llr_valid_i)
        else $error("llr_valid_o high on consecutive cycles");

endmodule

bind rx_frontend rx_frontend_asserts #(.CIC_RATE(CIC_RATE)) u_asserts (
    .clk_i(clk_i),
    .reset_ni(reset_ni),
    .cyc_i(wb_cyc_i),
    .stb_i(wb_stb_i),
    .ack_i(wb_ack_o),
    .llr_valid_i(llr_valid_o)
);

// ==== tests/tb_rx_frontend.sv ====
`timescale 1ns/1ns

module tb_rx_frontend;
    import rx_pkg::*;

    localparam int CIC_RATE     = 4;
    localparam int RESET_CYC    = 10;
    localparam int N_CONST      = 64;
    localparam int N_QUARTER    = 32;
    localparam int N_RANDOM     = 203;
    localparam int DRAIN_CYCLES = 8;
    // register traffic and drains plus up to three idle cycles per random sample
    localparam int STIM_CYCLES  = RESET_CYC + 80 + N_CONST + N_QUARTER + 4 * N_RANDOM;
    localparam int MAX_CYCLES   = 2 * STIM_CYCLES + 200;
    localparam int TAPS         = CIC_ORDER * (CIC_RATE - 1) + 1;
    localparam int GROWTH       = CIC_ORDER * $clog2(CIC_RATE);

    logic                        clk_i = 1'b0;
    logic                        reset_ni;
    logic                        wb_cyc_i;
    logic                        wb_stb_i;
    logic                        wb_we_i;
    logic [WB_ADDR_W-1:0]        wb_adr_i;
    logic [WB_DATA_W-1:0]        wb_dat_i;
    logic [WB_DATA_W-1:0]        wb_dat_o;
    logic                        wb_ack_o;
    logic                        in_valid_i;
    logic signed [IQ_W-1:0]      in_i_i;
    logic signed [IQ_W-1:0]      in_q_i;
    logic                        llr_valid_o;
    logic signed [LLR_W-1:0]     llr_i_o;
    logic signed [LLR_W-1:0]     llr_q_o;

    // reference model state
    longint      taps [TAPS];
    int          hist_i [$];
    int          hist_q [$];
    int          exp_i_q [$];
    int          exp_q_q [$];
    int          model_phase = 0;
    int          model_count = 0;
    int          cfg_inc = 0;
    int          cfg_shift = 0;
    int          errors = 0;
    int          pairs = 0;
    int          n_inputs = 0;
    int          cycles = 0;
    int          last_llr_i = 0;
    int          last_llr_q = 0;
    logic [31:0] rand_state;

    rx_frontend #(.CIC_RATE(CIC_RATE)) DUT (
        .clk_i(clk_i), .reset_ni(reset_ni),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
        .in_valid_i(in_valid_i), .in_i_i(in_i_i), .in_q_i(in_q_i),
        .llr_valid_o(llr_valid_o), .llr_i_o(llr_i_o), .llr_q_o(llr_q_o)
    );

    always #20 clk_i = ~clk_i;

    function automatic int lcg_next();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return int'(rand_state[30:16]);
    endfunction

    function automatic int neg_sat(input int x);
        return (x == -(1 << (IQ_W - 1))) ? (1 << (IQ_W - 1)) - 1 : -x;
    endfunction

    function automatic int clip_llr(input int x, input int sh);
        int lim;
        int scaled;
        lim = (1 << (LLR_W - 1)) - 1;
        scaled = x >>> sh;
        return (scaled > lim) ? lim : (scaled < -lim - 1) ? -lim - 1 : scaled;
    endfunction

    // cascade of CIC_ORDER boxcars of length CIC_RATE
    function automatic void build_taps();
        longint cur [TAPS];
        longint nxt [TAPS];
        for (int t = 0; t < TAPS; t++) begin
            cur[t] = (t < CIC_RATE) ? 1 : 0;
        end
        for (int s = 1; s < CIC_ORDER; s++) begin
            for (int t = 0; t < TAPS; t++) begin
                nxt[t] = 0;
            end
            for (int t = 0; t < TAPS; t++) begin
                for (int b = 0; b < CIC_RATE; b++) begin
                    if (t + b < TAPS) begin
                        nxt[t + b] += cur[t];
                    end
                end
            end
            cur = nxt;
        end
        taps = cur;
    endfunction

    // rotate, filter and demap one input and queue a pair when a group completes
    function automatic void model_sample(input int in_i, input int in_q);
        int     k;
        int     ri;
        int     rq;
        longint acc_i;
        longint acc_q;
        k = (model_phase >> (PHASE_W - 2)) & 3;
        ri = (k == 0) ? in_i : (k == 1) ? in_q : (k == 2) ? neg_sat(in_i) : neg_sat(in_q);
        rq = (k == 0) ? in_q : (k == 1) ? neg_sat(in_i) : (k == 2) ? neg_sat(in_q) : in_i;
        model_phase = (model_phase + cfg_inc) % (1 << PHASE_W);
        hist_i.push_front(ri);
        hist_q.push_front(rq);
        if (hist_i.size() > TAPS) begin
            void'(hist_i.pop_back());
            void'(hist_q.pop_back());
        end
        model_count++;
        if (model_count % CIC_RATE == 0) begin
            acc_i = 0;
            acc_q = 0;
            for (int n = 0; n < hist_i.size(); n++) begin
                acc_i += taps[n] * hist_i[n];
                acc_q += taps[n] * hist_q[n];
            end
            exp_i_q.push_back(clip_llr(int'(acc_i >>> GROWTH), cfg_shift));
            exp_q_q.push_back(clip_llr(int'(acc_q >>> GROWTH), cfg_shift));
        end
    endfunction

    task automatic check(input string what, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("error at %0t ns: %s got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #5;
    endtask

    task automatic wb_access(input logic we, input logic [WB_ADDR_W-1:0] adr,
                             input logic [WB_DATA_W-1:0] wdata,
                             output logic [WB_DATA_W-1:0] rdata);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        next_cycle();
        while (wb_ack_o !== 1'b1) begin
            next_cycle();
        end
        rdata = wb_dat_o;
        next_cycle();
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wb_write(input logic [WB_ADDR_W-1:0] adr, input logic [WB_DATA_W-1:0] data);
        logic [WB_DATA_W-1:0] unused_rd;
        wb_access(1'b1, adr, data, unused_rd);
    endtask

    task automatic wb_read_check(input logic [WB_ADDR_W-1:0] adr, input int exp,
                                 input string what);
        logic [WB_DATA_W-1:0] rd;
        wb_access(1'b0, adr, '0, rd);
        check(what, int'(rd), exp);
    endtask

    task automatic set_config(input int inc, input int shift);
        wb_write(REG_PHASE_INC, WB_DATA_W'(inc));
        wb_write(REG_LLR_SHIFT, WB_DATA_W'(shift));
        cfg_inc   = inc;
        cfg_shift = shift;
    endtask

    task automatic send_sample(input int in_i, input int in_q, input int gap);
        in_valid_i = 1'b1;
        in_i_i     = IQ_W'(in_i);
        in_q_i     = IQ_W'(in_q);
        model_sample(in_i, in_q);
        n_inputs++;
        next_cycle();
        in_valid_i = 1'b0;
        repeat (gap) next_cycle();
    endtask

    // a pair leaves the DUT three cycles after the input that completes its group
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_i_q.size() != 0 && waited < DRAIN_CYCLES) begin
            next_cycle();
            waited++;
        end
    endtask

    // ----------------------------------------------------------------------
    // output comparison at mid cycle
    // ----------------------------------------------------------------------
    always @(negedge clk_i) begin
        if (llr_valid_o === 1'b1) begin
            pairs++;
            if (exp_i_q.size() == 0) begin
                errors++;
                $display("unexpected LLR output at %0t ns while no pair was expected", $time);
            end else begin
                check("llr i", int'(llr_i_o), exp_i_q.pop_front());
                check("llr q", int'(llr_q_o), exp_q_q.pop_front());
                last_llr_i = int'(llr_i_o);
                last_llr_q = int'(llr_q_o);
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        int inc;
        int shift;
        int gap;
        rand_state = 32'd76;
        build_taps();
        reset_ni   = 1'b0;
        wb_cyc_i   = 1'b0;
        wb_stb_i   = 1'b0;
        wb_we_i    = 1'b0;
        wb_adr_i   = '0;
        wb_dat_i   = '0;
        in_valid_i = 1'b0;
        in_i_i     = '0;
        in_q_i     = '0;
        repeat (RESET_CYC) @(posedge clk_i);
        #5;
        reset_ni = 1'b1;

        // register access
        wb_read_check(REG_PHASE_INC, 0, "phase inc after reset");
        wb_read_check(REG_LLR_SHIFT, 0, "llr shift after reset");
        wb_write(REG_PHASE_INC, 32'hABCD_1234);
        wb_write(REG_LLR_SHIFT, 32'h0000_000D);
        wb_write(4'd7, 32'hFFFF_FFFF);
        wb_read_check(REG_PHASE_INC, 32'h1234, "phase inc readback");
        wb_read_check(REG_LLR_SHIFT, 5, "llr shift readback");
        wb_read_check(4'd7, 0, "unmapped address");

        // constant input, no rotation
        set_config(0, 0);
        for (int n = 0; n < N_CONST; n++) begin
            send_sample(100, -300, 0);
        end
        wait_drain();
        check("settled llr i", last_llr_i, 100);
        check("settled llr q", last_llr_q, -128);

        // quarter turn per sample with the most negative I
        set_config(16384, 0);
        for (int n = 0; n < N_QUARTER; n++) begin
            send_sample(-2048, 700, 0);
        end
        wait_drain();

        // random config, data and gaps
        inc   = lcg_next() & 16'hFFFF;
        shift = lcg_next() % 8;
        set_config(inc, shift);
        for (int n = 0; n < N_RANDOM; n++) begin
            gap = (lcg_next() % 4 == 0) ? lcg_next() % 4 : 0;
            send_sample(lcg_next() % 4096 - 2048, lcg_next() % 4096 - 2048, gap);
        end
        wait_drain();
        // room for a stray pair from the trailing inputs
        repeat (DRAIN_CYCLES) next_cycle();

        check("llr pair count", pairs, n_inputs / CIC_RATE);
        check("pairs left in queue", exp_i_q.size(), 0);
        $display("errors: %0d, inputs: %0d, llr pairs: %0d", errors, n_inputs, pairs);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
src/rx_pkg.sv
src/rx_regs.sv
src/cfo_rotator.sv
src/cic_decimator.sv
src/llr_demapper.sv
src/rx_frontend.sv
tests/rx_frontend_asserts.sv
tests/tb_rx_frontend.sv

// ==== Makefile ====
SRCS := $(shell cat list.f)

obj_dir/Vtb_rx_frontend: list.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_rx_frontend -f list.f

run: obj_dir/Vtb_rx_frontend
	./obj_dir/Vtb_rx_frontend | tee sim.log
	! grep -q "Some tests failed" sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
